// File: build.f
src/rs_pkg.sv
src/rs_entry.sv
src/rs_alloc.sv
src/rs_table.sv
src/rs_issue_select.sv
src/rs_top.sv
tb/tb_clock_gen.sv
tb/rs_tb.sv

// File: tb/rs_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rs_tb;
    import rs_pkg::*;

    localparam int MAX_STEPS = 160;
    localparam int N_RANDOM  = 70;

    // one table row, stimulus then expected outputs
    typedef struct packed {
        rs_packet_t [DISPATCH_WIDTH-1:0] disp;
        cdb_t [CDB_WIDTH-1:0]            cdb;
        logic                            resolve;
        logic                            mispredict;
        logic                            flush;
        logic [FU_NUM-1:0]               fu_ready;
        logic [FU_NUM-1:0]               exp_valid;
        logic [FU_NUM-1:0]               exp_spec;
        rob_idx_t [FU_NUM-1:0]           exp_rob;
        rs_count_t                       exp_free;
        logic                            exp_full;
    } step_t;

    logic                              clock;
    logic                              reset;
    logic                              flush_i;
    rs_packet_t [DISPATCH_WIDTH-1:0]   disp_i;
    cdb_t [CDB_WIDTH-1:0]              cdb_i;
    logic                              br_resolve_i;
    logic                              br_mispredict_i;
    logic [FU_NUM-1:0]                 fu_ready_i;
    rs_count_t                         free_slots_o;
    logic                              full_o;
    issue_t [FU_NUM-1:0]               issue_o;

    step_t       steps [MAX_STEPS];
    int          n_steps;
    int          n_directed;
    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] rng_state;

    // reference model state
    logic        m_valid [RS_DEPTH];
    logic        m_spec [RS_DEPTH];
    rs_packet_t  m_pkt [RS_DEPTH];
    logic        m_pend;
    logic        m_iv [FU_NUM];
    logic        m_ispec [FU_NUM];
    rob_idx_t    m_irob [FU_NUM];

    tb_clock_gen i_clock_gen (
        .clock_o (clock),
        .reset_o (reset)
    );

    rs_top i_dut (
        .clock           (clock),
        .reset           (reset),
        .flush_i         (flush_i),
        .disp_i          (disp_i),
        .free_slots_o    (free_slots_o),
        .full_o          (full_o),
        .cdb_i           (cdb_i),
        .br_resolve_i    (br_resolve_i),
        .br_mispredict_i (br_mispredict_i),
        .fu_ready_i      (fu_ready_i),
        .issue_o         (issue_o)
    );

    // ====================
    // helpers
    // ====================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // idle row, all units accepting
    task automatic new_step();
        steps[n_steps]          = '0;
        steps[n_steps].fu_ready = '1;
        n_steps++;
    endtask

    function automatic rs_packet_t make_pkt(input fu_type_e fu, input int rob,
                                            input int t1, input logic r1,
                                            input int t2, input logic r2);
        rs_packet_t p;
        p            = '0;
        p.valid      = 1'b1;
        p.fu_type    = fu;
        p.alu_func   = alu_func_t'(rob);
        p.imm        = 32'h1000 + rob;
        p.rob_idx    = rob_idx_t'(rob);
        p.dest_tag   = phys_tag_t'(rob + 32);
        p.src1_tag   = phys_tag_t'(t1);
        p.src1_ready = r1;
        p.src2_tag   = phys_tag_t'(t2);
        p.src2_ready = r2;
        return p;
    endfunction

    task automatic put_disp(input int s, input fu_type_e fu, input int rob,
                            input int t1, input logic r1);
        steps[n_steps-1].disp[s] = make_pkt(fu, rob, t1, r1, 1, 1'b1);
    endtask

    task automatic put_cdb(input int c, input int tag);
        steps[n_steps-1].cdb[c].valid = 1'b1;
        steps[n_steps-1].cdb[c].tag   = phys_tag_t'(tag);
    endtask

    // compares one issue register with its expected row
    task automatic check_issue(input int t, input step_t st);
        rs_packet_t ref_pkt;
        check($sformatf("issue_o[%0d].valid", t), 64'(issue_o[t].valid),
              64'(st.exp_valid[t]));
        if (st.exp_valid[t]) begin
            // payload fields follow from the rob index of the packet
            ref_pkt = make_pkt(FU_ALU, int'(st.exp_rob[t]), 0, 1'b0, 0, 1'b0);
            check($sformatf("issue_o[%0d].rob_idx", t), 64'(issue_o[t].rob_idx),
                  64'(ref_pkt.rob_idx));
            check($sformatf("issue_o[%0d].alu_func", t), 64'(issue_o[t].alu_func),
                  64'(ref_pkt.alu_func));
            check($sformatf("issue_o[%0d].imm", t), 64'(issue_o[t].imm),
                  64'(ref_pkt.imm));
            check($sformatf("issue_o[%0d].dest_tag", t), 64'(issue_o[t].dest_tag),
                  64'(ref_pkt.dest_tag));
            check($sformatf("issue_o[%0d].spec", t), 64'(issue_o[t].spec),
                  64'(st.exp_spec[t]));
        end
    endtask

    function automatic rs_packet_t wake(input rs_packet_t p, input cdb_t [CDB_WIDTH-1:0] cdb);
        for (int c = 0; c < CDB_WIDTH; c++) begin
            if (cdb[c].valid && cdb[c].tag == p.src1_tag) p.src1_ready = 1'b1;
            if (cdb[c].valid && cdb[c].tag == p.src2_tag) p.src2_ready = 1'b1;
        end
        return p;
    endfunction

    // ====================
    // reference model
    // ====================

    // one rising edge of the scheduler
    task automatic model_edge(input step_t st);
        logic                      mis;
        logic                      ok;
        logic                      below;
        logic                      any_br;
        logic                      can_load;
        logic [RS_DEPTH-1:0]       taken;
        logic [RS_DEPTH-1:0]       rel;
        logic [RS_DEPTH-1:0]       wr;
        logic [RS_DEPTH-1:0]       wspec;
        rs_packet_t [RS_DEPTH-1:0] wpkt;
        logic                      sspec;
        int                        pick;
        mis    = st.resolve && st.mispredict;
        ok     = st.resolve && !st.mispredict;
        taken  = '0;
        wr     = '0;
        wspec  = '0;
        wpkt   = '0;
        rel    = '0;
        below  = 1'b0;
        any_br = 1'b0;
        // allocation into lowest free entries, slot order
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            sspec = (m_pend && !st.resolve) || below;
            if (st.disp[s].valid) begin
                for (int e = 0; e < RS_DEPTH; e++) begin
                    if (!m_valid[e] && !taken[e]) begin
                        taken[e] = 1'b1;
                        wr[e]    = !mis;
                        wspec[e] = sspec;
                        wpkt[e]  = st.disp[s];
                        break;
                    end
                end
                if (st.disp[s].fu_type == FU_BRANCH) begin
                    below  = 1'b1;
                    any_br = 1'b1;
                end
            end
        end
        // per type selection and issue register
        for (int t = 0; t < FU_NUM; t++) begin
            can_load = !m_iv[t] || st.fu_ready[t];
            pick     = -1;
            for (int e = 0; e < RS_DEPTH; e++) begin
                if (pick < 0 && m_valid[e] && m_pkt[e].src1_ready && m_pkt[e].src2_ready
                    && !(mis && m_spec[e]) && m_pkt[e].fu_type == fu_type_e'(t)) begin
                    pick = e;
                end
            end
            if (can_load) begin
                m_iv[t]    = (pick >= 0);
                m_ispec[t] = (pick >= 0) && m_spec[pick] && !ok;
                if (pick >= 0) begin
                    m_irob[t] = m_pkt[pick].rob_idx;
                    rel[pick] = 1'b1;
                end
            end else if (mis && m_ispec[t]) begin
                m_iv[t]    = 1'b0;
                m_ispec[t] = 1'b0;
            end else if (ok) begin
                m_ispec[t] = 1'b0;
            end
        end
        // entries
        for (int e = 0; e < RS_DEPTH; e++) begin
            m_pkt[e] = wake(wr[e] ? wpkt[e] : m_pkt[e], st.cdb);
            if (rel[e] || (mis && m_spec[e])) begin
                m_valid[e] = 1'b0;
                m_spec[e]  = 1'b0;
            end else if (wr[e]) begin
                m_valid[e] = 1'b1;
                m_spec[e]  = wspec[e];
            end else if (ok) begin
                m_spec[e] = 1'b0;
            end
        end
        if (mis) m_pend = 1'b0;
        else if (any_br) m_pend = 1'b1;
        else if (st.resolve) m_pend = 1'b0;
        // flush beats everything
        if (st.flush) begin
            m_pend = 1'b0;
            for (int e = 0; e < RS_DEPTH; e++) begin
                m_valid[e] = 1'b0;
                m_spec[e]  = 1'b0;
            end
            for (int t = 0; t < FU_NUM; t++) begin
                m_iv[t]    = 1'b0;
                m_ispec[t] = 1'b0;
            end
        end
    endtask

    task automatic random_step(input int i);
        logic [31:0] r;
        steps[i] = '0;
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            r = next_rand();
            if (r[0]) begin
                steps[i].disp[s] = make_pkt(fu_type_e'(r[2:1]), int'(r[12:8]),
                                            int'(r[15:13]), r[3], int'(r[18:16]), r[4]);
            end
        end
        r = next_rand();
        steps[i].cdb[0].valid = r[0];
        steps[i].cdb[0].tag   = phys_tag_t'(r[3:1]);
        steps[i].cdb[1].valid = r[4];
        steps[i].cdb[1].tag   = phys_tag_t'(r[7:5]);
        steps[i].resolve      = (r[10:8] == 3'd0);
        steps[i].mispredict   = r[11];
        steps[i].flush        = (r[16:12] == 5'd0);
        steps[i].fu_ready     = r[20:17] | r[24:21];
    endtask

    // generates random rows and fills every expected column
    task automatic build_expected();
        int free;
        int used;
        m_pend = 1'b0;
        for (int e = 0; e < RS_DEPTH; e++) begin
            m_valid[e] = 1'b0;
            m_spec[e]  = 1'b0;
            m_pkt[e]   = '0;
        end
        for (int t = 0; t < FU_NUM; t++) begin
            m_iv[t]    = 1'b0;
            m_ispec[t] = 1'b0;
            m_irob[t]  = '0;
        end
        for (int i = 0; i < n_steps; i++) begin
            if (i >= n_directed) random_step(i);
            free = 0;
            for (int e = 0; e < RS_DEPTH; e++) free += !m_valid[e];
            steps[i].exp_full = (free == 0);
            steps[i].exp_free = rs_count_t'((free > DISPATCH_WIDTH) ? DISPATCH_WIDTH : free);
            for (int t = 0; t < FU_NUM; t++) begin
                steps[i].exp_valid[t] = m_iv[t];
                steps[i].exp_spec[t]  = m_ispec[t];
                steps[i].exp_rob[t]   = m_irob[t];
            end
            // dispatch never offers more than the free count
            used = 0;
            for (int s = 0; s < DISPATCH_WIDTH; s++) begin
                if (steps[i].disp[s].valid) begin
                    if (used >= free) steps[i].disp[s].valid = 1'b0;
                    else used++;
                end
            end
            model_edge(steps[i]);
        end
    endtask

    // ====================
    // directed rows
    // ====================

    task automatic build_directed();
        // ready packets, two types in one cycle
        new_step();
        put_disp(0, FU_ALU, 1, 2, 1'b1);
        put_disp(1, FU_MULT, 2, 2, 1'b1);
        repeat (3) new_step();
        // wakeup two cycles after the tag
        new_step();
        put_disp(0, FU_ALU, 3, 10, 1'b0);
        repeat (2) new_step();
        put_cdb(0, 10);
        repeat (3) new_step();
        // same cycle bypass
        new_step();
        put_disp(0, FU_MEM, 4, 11, 1'b0);
        put_cdb(1, 11);
        repeat (3) new_step();
        // ALU stalled, table fills up
        for (int k = 0; k < 6; k++) begin
            new_step();
            put_disp(0, FU_ALU, 5 + 2 * k, 0, 1'b1);
            put_disp(1, FU_ALU, 6 + 2 * k, 0, 1'b1);
            steps[n_steps-1].fu_ready = 4'b1110;
        end
        repeat (12) new_step();
        // branch, then shadowed packets, some held in the ALU register
        new_step();
        put_disp(0, FU_BRANCH, 20, 0, 1'b1);
        put_disp(1, FU_ALU, 21, 30, 1'b0);
        new_step();
        put_disp(0, FU_ALU, 22, 0, 1'b1);
        steps[n_steps-1].fu_ready = 4'b0110;
        new_step();
        steps[n_steps-1].fu_ready = 4'b0110;
        new_step();
        put_disp(0, FU_ALU, 23, 0, 1'b1);
        steps[n_steps-1].resolve    = 1'b1;
        steps[n_steps-1].mispredict = 1'b1;
        steps[n_steps-1].fu_ready   = 4'b0110;
        repeat (3) new_step();
        // correct resolve lifts the shadow
        new_step();
        put_disp(0, FU_BRANCH, 24, 0, 1'b1);
        put_disp(1, FU_ALU, 25, 31, 1'b0);
        new_step();
        put_disp(0, FU_MULT, 26, 0, 1'b1);
        new_step();
        steps[n_steps-1].resolve = 1'b1;
        new_step();
        put_disp(0, FU_BRANCH, 27, 0, 1'b1);
        new_step();
        steps[n_steps-1].resolve    = 1'b1;
        steps[n_steps-1].mispredict = 1'b1;
        new_step();
        put_cdb(0, 31);
        repeat (3) new_step();
        // flush with waiting entries and a held issue register
        new_step();
        put_disp(0, FU_MEM, 28, 40, 1'b0);
        put_disp(1, FU_MULT, 29, 0, 1'b1);
        new_step();
        steps[n_steps-1].fu_ready = 4'b0000;
        new_step();
        steps[n_steps-1].flush    = 1'b1;
        steps[n_steps-1].fu_ready = 4'b0000;
        // tag of the flushed MEM entry, nothing may issue from it
        new_step();
        put_cdb(0, 40);
        repeat (2) new_step();
        n_directed = n_steps;
        n_steps    = n_steps + N_RANDOM;
    endtask

    // ====================
    // run
    // ====================

    // ends the run if the main loop stalls
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > n_steps + 50) begin
            $display("timeout: run exceeded %0d cycles without finishing", n_steps + 50);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        flush_i         = 1'b0;
        disp_i          = '0;
        cdb_i           = '0;
        br_resolve_i    = 1'b0;
        br_mispredict_i = 1'b0;
        fu_ready_i      = '1;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        n_steps         = 0;
        rng_state       = 32'd51144;
        build_directed();
        build_expected();
        do @(negedge clock); while (reset);
        for (int i = 0; i < n_steps; i++) begin
            @(posedge clock);
            disp_i          <= steps[i].disp;
            cdb_i           <= steps[i].cdb;
            br_resolve_i    <= steps[i].resolve;
            br_mispredict_i <= steps[i].mispredict;
            flush_i         <= steps[i].flush;
            fu_ready_i      <= steps[i].fu_ready;
            @(negedge clock);
            check("free_slots_o", 64'(free_slots_o), 64'(steps[i].exp_free));
            check("full_o", 64'(full_o), 64'(steps[i].exp_full));
            for (int t = 0; t < FU_NUM; t++) begin
                check_issue(t, steps[i]);
            end
        end
        $display("steps %0d, checks %0d, errors %0d", n_steps, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);
    // 8 ns period
    initial begin
        clock_o = 1'b0;
        forever #4 clock_o = ~clock_o;
    end

    // reset held for three rising edges
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clock_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: src/rs_top.sv
`timescale 1ns/10ps
`default_nettype none

module rs_top (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            flush_i,
    // dispatch side
    input  rs_pkg::rs_packet_t [rs_pkg::DISPATCH_WIDTH-1:0] disp_i,
    output rs_pkg::rs_count_t                               free_slots_o,
    output logic                                            full_o,
    // result broadcast
    input  rs_pkg::cdb_t [rs_pkg::CDB_WIDTH-1:0]            cdb_i,
    // branch resolution
    input  logic                                            br_resolve_i,
    input  logic                                            br_mispredict_i,
    // functional units
    input  logic [rs_pkg::FU_NUM-1:0]                       fu_ready_i,
    output rs_pkg::issue_t [rs_pkg::FU_NUM-1:0]             issue_o
);
    import rs_pkg::*;

    // table to selector
    rs_packet_t [RS_DEPTH-1:0] entries;
    logic [RS_DEPTH-1:0]       entry_spec;
    logic [RS_DEPTH-1:0]       entry_ready;
    // selector back to table
    logic [RS_DEPTH-1:0]       issue_grant;

    // ====================
    // station
    // ====================

    rs_table i_table (
        .clock           (clock),
        .reset           (reset),
        .flush_i         (flush_i),
        .disp_i          (disp_i),
        .cdb_i           (cdb_i),
        .br_resolve_i    (br_resolve_i),
        .br_mispredict_i (br_mispredict_i),
        .release_i       (issue_grant),
        .entries_o       (entries),
        .spec_o          (entry_spec),
        .ready_o         (entry_ready),
        .free_slots_o    (free_slots_o),
        .full_o          (full_o)
    );

    // ====================
    // issue
    // ====================

    rs_issue_select i_select (
        .clock           (clock),
        .reset           (reset),
        .flush_i         (flush_i),
        .entries_i       (entries),
        .spec_i          (entry_spec),
        .ready_i         (entry_ready),
        .br_resolve_i    (br_resolve_i),
        .br_mispredict_i (br_mispredict_i),
        .fu_ready_i      (fu_ready_i),
        .release_o       (issue_grant),
        .issue_o         (issue_o)
    );

endmodule

`default_nettype wire

// File: src/rs_issue_select.sv
`timescale 1ns/10ps
`default_nettype none

module rs_issue_select (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      flush_i,
    input  rs_pkg::rs_packet_t [rs_pkg::RS_DEPTH-1:0] entries_i,
    input  logic [rs_pkg::RS_DEPTH-1:0]               spec_i,
    input  logic [rs_pkg::RS_DEPTH-1:0]               ready_i,
    input  logic                                      br_resolve_i,
    input  logic                                      br_mispredict_i,
    input  logic [rs_pkg::FU_NUM-1:0]                 fu_ready_i,
    output logic [rs_pkg::RS_DEPTH-1:0]               release_o,
    output rs_pkg::issue_t [rs_pkg::FU_NUM-1:0]       issue_o
);
    import rs_pkg::*;

    logic                mispredict;
    logic                resolve_ok;
    logic [RS_DEPTH-1:0] eligible;
    logic [FU_NUM-1:0]   can_load;
    logic [FU_NUM-1:0]   pick_found;
    rs_idx_t             pick_idx [FU_NUM];
    issue_t [FU_NUM-1:0] pick_data;
    // issue register control
    logic [FU_NUM-1:0]   valid_q;
    logic [FU_NUM-1:0]   spec_q;
    // issue register payload
    issue_t [FU_NUM-1:0] data_q;

    assign mispredict = br_resolve_i && br_mispredict_i;
    assign resolve_ok = br_resolve_i && !br_mispredict_i;
    // shadowed entries vanish at this edge, skip them
    assign eligible   = ready_i & ~(spec_i & {RS_DEPTH{mispredict}});

    // ====================
    // per type picker
    // ====================

    always_comb begin
        release_o = '0;
        for (int t = 0; t < FU_NUM; t++) begin
            // empty, or current value leaves this edge
            can_load[t]   = !valid_q[t] || fu_ready_i[t];
            pick_found[t] = 1'b0;
            pick_idx[t]   = '0;
            // walk down so lowest index wins
            for (int i = RS_DEPTH - 1; i >= 0; i--) begin
                if (eligible[i] && (entries_i[i].fu_type == fu_type_e'(t))) begin
                    pick_found[t] = 1'b1;
                    pick_idx[t]   = rs_idx_t'(i);
                end
            end
            pick_data[t].valid    = pick_found[t];
            pick_data[t].alu_func = entries_i[pick_idx[t]].alu_func;
            pick_data[t].imm      = entries_i[pick_idx[t]].imm;
            pick_data[t].rob_idx  = entries_i[pick_idx[t]].rob_idx;
            pick_data[t].dest_tag = entries_i[pick_idx[t]].dest_tag;
            // correct resolve this cycle already lifts the shadow
            pick_data[t].spec     = spec_i[pick_idx[t]] && !resolve_ok;
            if (pick_found[t] && can_load[t]) begin
                release_o[pick_idx[t]] = 1'b1;
            end
        end
    end

    // ====================
    // issue registers
    // ====================

    always_ff @(posedge clock) begin
        for (int t = 0; t < FU_NUM; t++) begin
            if (reset || flush_i) begin
                valid_q[t] <= 1'b0;
                spec_q[t]  <= 1'b0;
            end else if (can_load[t]) begin
                valid_q[t] <= pick_found[t];
                spec_q[t]  <= pick_found[t] && pick_data[t].spec;
            end else if (mispredict && spec_q[t]) begin
                // held behind a stalled unit, killed by mispredict
                valid_q[t] <= 1'b0;
                spec_q[t]  <= 1'b0;
            end else if (resolve_ok) begin
                spec_q[t] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int t = 0; t < FU_NUM; t++) begin
            if (can_load[t] && pick_found[t]) begin
                data_q[t] <= pick_data[t];
            end
        end
    end

    always_comb begin
        for (int t = 0; t < FU_NUM; t++) begin
            issue_o[t]       = data_q[t];
            issue_o[t].valid = valid_q[t];
            issue_o[t].spec  = spec_q[t];
        end
    end

endmodule

`default_nettype wire

// File: src/rs_table.sv
`timescale 1ns/10ps
`default_nettype none

module rs_table (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            flush_i,
    input  rs_pkg::rs_packet_t [rs_pkg::DISPATCH_WIDTH-1:0] disp_i,
    input  rs_pkg::cdb_t [rs_pkg::CDB_WIDTH-1:0]            cdb_i,
    input  logic                                            br_resolve_i,
    input  logic                                            br_mispredict_i,
    input  logic [rs_pkg::RS_DEPTH-1:0]                     release_i,
    output rs_pkg::rs_packet_t [rs_pkg::RS_DEPTH-1:0]       entries_o,
    output logic [rs_pkg::RS_DEPTH-1:0]                     spec_o,
    output logic [rs_pkg::RS_DEPTH-1:0]                     ready_o,
    output rs_pkg::rs_count_t                               free_slots_o,
    output logic                                            full_o
);
    import rs_pkg::*;

    logic                                    mispredict;
    logic                                    resolve_ok;
    logic                                    branch_pending_q;
    logic                                    disp_branch;
    logic [DISPATCH_WIDTH-1:0]               slot_valid;
    logic [DISPATCH_WIDTH-1:0]               slot_spec;
    logic [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] grant;
    logic [RS_DEPTH-1:0]                     empty;
    logic [RS_DEPTH-1:0]                     write_en;
    logic [RS_DEPTH-1:0]                     write_spec;
    rs_packet_t [RS_DEPTH-1:0]               write_pkt;

    assign mispredict = br_resolve_i && br_mispredict_i;
    assign resolve_ok = br_resolve_i && !br_mispredict_i;

    // ====================
    // branch shadow
    // ====================

    always_comb begin
        logic branch_below;
        branch_below = 1'b0;
        disp_branch  = 1'b0;
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            slot_valid[s] = disp_i[s].valid;
            // pending branch resolving now no longer shadows this slot
            slot_spec[s]  = (branch_pending_q && !br_resolve_i) || branch_below;
            // branch itself not speculative, only slots above it
            if (disp_i[s].valid && (disp_i[s].fu_type == FU_BRANCH)) begin
                branch_below = 1'b1;
                disp_branch  = 1'b1;
            end
        end
    end

    // one outstanding branch at a time
    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            branch_pending_q <= 1'b0;
        end else if (mispredict) begin
            branch_pending_q <= 1'b0;
        end else if (disp_branch) begin
            branch_pending_q <= 1'b1;
        end else if (br_resolve_i) begin
            branch_pending_q <= 1'b0;
        end
    end

    // ====================
    // allocation routing
    // ====================

    rs_alloc i_alloc (
        .empty_i      (empty),
        .request_i    (slot_valid),
        .grant_o      (grant),
        .free_slots_o (free_slots_o),
        .full_o       (full_o)
    );

    always_comb begin
        write_en   = '0;
        write_spec = '0;
        write_pkt  = '0;
        // nothing enters on a mispredict edge
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            for (int e = 0; e < RS_DEPTH; e++) begin
                if (grant[s][e] && !mispredict) begin
                    write_en[e]   = 1'b1;
                    write_spec[e] = slot_spec[s];
                    write_pkt[e]  = disp_i[s];
                end
            end
        end
    end

    // ====================
    // entry array
    // ====================

    for (genvar e = 0; e < RS_DEPTH; e++) begin : g_entry
        rs_entry i_entry (
            .clock        (clock),
            .reset        (reset),
            .flush_i      (flush_i),
            .squash_i     (mispredict),
            .clear_spec_i (resolve_ok),
            .write_i      (write_en[e]),
            .release_i    (release_i[e]),
            .spec_i       (write_spec[e]),
            .packet_i     (write_pkt[e]),
            .cdb_i        (cdb_i),
            .packet_o     (entries_o[e]),
            .spec_o       (spec_o[e]),
            .empty_o      (empty[e]),
            .ready_o      (ready_o[e])
        );
    end

endmodule

`default_nettype wire

// File: src/rs_alloc.sv
`timescale 1ns/10ps
`default_nettype none

module rs_alloc (
    input  logic [rs_pkg::RS_DEPTH-1:0]                             empty_i,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0]                       request_i,
    output logic [rs_pkg::DISPATCH_WIDTH-1:0][rs_pkg::RS_DEPTH-1:0] grant_o,
    output rs_pkg::rs_count_t                                       free_slots_o,
    output logic                                                    full_o
);
    import rs_pkg::*;

    // ====================
    // slot to entry grant
    // ====================

    always_comb begin
        logic [RS_DEPTH-1:0] taken;
        logic                found;
        taken   = '0;
        grant_o = '0;
        // slot 0 first, each slot takes lowest entry still free
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            found = 1'b0;
            for (int e = 0; e < RS_DEPTH; e++) begin
                if (request_i[s] && empty_i[e] && !taken[e] && !found) begin
                    grant_o[s][e] = 1'b1;
                    taken[e]      = 1'b1;
                    found         = 1'b1;
                end
            end
        end
    end

    // ====================
    // free count
    // ====================

    always_comb begin
        free_slots_o = '0;
        // dispatch only needs to know up to its own width
        for (int e = 0; e < RS_DEPTH; e++) begin
            if (empty_i[e] && (free_slots_o < rs_count_t'(DISPATCH_WIDTH))) begin
                free_slots_o = free_slots_o + rs_count_t'(1);
            end
        end
    end

    assign full_o = ~|empty_i;

endmodule

`default_nettype wire

// File: src/rs_entry.sv
`timescale 1ns/10ps
`default_nettype none

module rs_entry (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 flush_i,
    input  logic                                 squash_i,
    input  logic                                 clear_spec_i,
    input  logic                                 write_i,
    input  logic                                 release_i,
    input  logic                                 spec_i,
    input  rs_pkg::rs_packet_t                   packet_i,
    input  rs_pkg::cdb_t [rs_pkg::CDB_WIDTH-1:0] cdb_i,
    output rs_pkg::rs_packet_t                   packet_o,
    output logic                                 spec_o,
    output logic                                 empty_o,
    output logic                                 ready_o
);
    import rs_pkg::*;

    // occupancy and branch shadow mark
    logic       valid_q;
    logic       spec_q;
    // stored instruction
    rs_packet_t data_q;

    // packet under tag compare, new one on write
    rs_packet_t cur_pkt;
    rs_packet_t next_pkt;
    logic       src1_hit;
    logic       src2_hit;
    logic       drop;

    // ====================
    // wakeup
    // ====================

    always_comb begin
        cur_pkt  = write_i ? packet_i : data_q;
        src1_hit = 1'b0;
        src2_hit = 1'b0;
        // same compare covers bypass on write and waiting sources
        for (int c = 0; c < CDB_WIDTH; c++) begin
            if (cdb_i[c].valid && (cdb_i[c].tag == cur_pkt.src1_tag)) begin
                src1_hit = 1'b1;
            end
            if (cdb_i[c].valid && (cdb_i[c].tag == cur_pkt.src2_tag)) begin
                src2_hit = 1'b1;
            end
        end
        next_pkt            = cur_pkt;
        next_pkt.src1_ready = cur_pkt.src1_ready | src1_hit;
        next_pkt.src2_ready = cur_pkt.src2_ready | src2_hit;
    end

    // leaves on issue, or on mispredict while in the branch shadow
    assign drop = release_i || (squash_i && spec_q);

    // ====================
    // state
    // ====================

    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            valid_q <= 1'b0;
            spec_q  <= 1'b0;
        end else if (drop) begin
            valid_q <= 1'b0;
            spec_q  <= 1'b0;
        end else if (write_i) begin
            valid_q <= 1'b1;
            spec_q  <= spec_i;
        end else if (clear_spec_i) begin
            // branch resolved correctly
            spec_q <= 1'b0;
        end
    end

    // payload, ready bits keep collecting tags every cycle
    always_ff @(posedge clock) begin
        data_q <= next_pkt;
    end

    // ====================
    // outputs
    // ====================

    always_comb begin
        packet_o       = data_q;
        packet_o.valid = valid_q;
    end

    assign spec_o  = spec_q;
    assign empty_o = !valid_q;
    // both operands present
    assign ready_o = valid_q && data_q.src1_ready && data_q.src2_ready;

endmodule

`default_nettype wire

// File: src/rs_pkg.sv
`default_nettype none

package rs_pkg;

    // ====================
    // sizes
    // ====================

    // station entries
    localparam int RS_DEPTH       = 8;
    // instructions offered per cycle
    localparam int DISPATCH_WIDTH = 2;
    // result broadcasts per cycle
    localparam int CDB_WIDTH      = 2;
    localparam int PHYS_REGS      = 64;
    localparam int ROB_DEPTH      = 32;
    // functional unit types, one issue port each
    localparam int FU_NUM         = 4;

    // ====================
    // vector types
    // ====================

    typedef logic [$clog2(PHYS_REGS)-1:0]        phys_tag_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]        rob_idx_t;
    typedef logic [$clog2(RS_DEPTH)-1:0]         rs_idx_t;
    // saturates at DISPATCH_WIDTH
    typedef logic [$clog2(DISPATCH_WIDTH+1)-1:0] rs_count_t;
    typedef logic [3:0]                          alu_func_t;
    typedef logic [31:0]                         imm_t;

    typedef enum logic [$clog2(FU_NUM)-1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_MEM    = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_e;

    // ====================
    // structs
    // ====================

    // renamed instruction from dispatch
    typedef struct packed {
        logic      valid;
        fu_type_e  fu_type;
        alu_func_t alu_func;
        imm_t      imm;
        rob_idx_t  rob_idx;
        phys_tag_t dest_tag;
        phys_tag_t src1_tag;
        logic      src1_ready;
        phys_tag_t src2_tag;
        logic      src2_ready;
    } rs_packet_t;

    // one result broadcast
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } cdb_t;

    // contents of one issue register
    typedef struct packed {
        logic      valid;
        alu_func_t alu_func;
        imm_t      imm;
        rob_idx_t  rob_idx;
        phys_tag_t dest_tag;
        logic      spec;
    } issue_t;

endpackage

`default_nettype wire
